// ==== blimp_pkg.sv ====
//------------------------------
// Shared widths, opcodes, instruction union,
// memory message and trace structs for the core
//------------------------------

package blimp_pkg;

  //------------------------------
  // Widths
  //------------------------------

  localparam int XLEN      = 32;
  // Opaque tag on memory messages, bit 0 is the fetch epoch
  localparam int OPAQ_BITS = 8;
  localparam int NUM_REGS  = 32;

  //------------------------------
  // RV32 opcodes and funct fields
  //------------------------------

  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  // M extension marker in funct7
  localparam logic [6:0] OPC_F7_MULDIV = 7'b0000001;

  //------------------------------
  // Memory messages
  //------------------------------

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e                op;
    logic [OPAQ_BITS-1:0]   opaque;
    logic [XLEN-1:0]        addr;
    logic [XLEN-1:0]        data;
  } mem_req_t;

  typedef struct packed {
    mem_op_e                op;
    logic [OPAQ_BITS-1:0]   opaque;
    logic [XLEN-1:0]        data;
  } mem_resp_t;

  //------------------------------
  // Instruction word, four views
  //------------------------------

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_t;

  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_ADDI,
    UOP_MUL,
    UOP_LW,
    UOP_SW,
    UOP_JAL,
    UOP_JALR
  } uop_e;

  //------------------------------
  // Pipeline and trace messages
  //------------------------------

  typedef struct packed {
    logic [XLEN-1:0] pc;
    inst_t           inst;
  } fetch_msg_t;

  typedef struct packed {
    uop_e            uop;
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] imm;
  } issue_msg_t;

  typedef struct packed {
    logic            val;
    logic [XLEN-1:0] pc;
    logic [4:0]      waddr;
    logic [XLEN-1:0] wdata;
    logic            wen;
  } trace_t;

endpackage

// ==== blimp_fetch.sv ====
//------------------------------
// Fetch unit with the pc, instruction requests,
// epoch tagging and wrong-path response drop
//------------------------------
`timescale 1ns/1ps

module blimp_fetch
  import blimp_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  output logic            imem_req_val,
  input  logic            imem_req_rdy,
  output mem_req_t        imem_req_msg,
  input  logic            imem_resp_val,
  output logic            imem_resp_rdy,
  input  mem_resp_t       imem_resp_msg,
  output logic            fetch_val,
  input  logic            fetch_rdy,
  output fetch_msg_t      fetch_msg,
  input  logic            redirect,
  input  logic [XLEN-1:0] redirect_pc
);

  logic [XLEN-1:0] pc;
  logic            epoch;
  // Request held here until the memory takes it
  logic [XLEN-1:0] req_pc;
  logic            req_epoch;

  // Two-slot queue with a wrap bit on each pointer
  logic [XLEN-1:0] q_pc [2];
  inst_t           q_inst [2];
  logic [1:0]      wr_ptr;
  logic [1:0]      rsp_ptr;
  logic [1:0]      rd_ptr;

  logic [1:0]      used;
  logic            req_xfer;
  logic            issue_ok;
  logic            resp_drop;
  logic            deq;

  // Responses always have a slot reserved
  assign imem_resp_rdy = 1'b1;

  assign req_xfer  = imem_req_val && imem_req_rdy;
  // Slots taken by queued entries plus the held request
  assign used      = (wr_ptr - rd_ptr) + {1'b0, imem_req_val};
  assign issue_ok  = (!imem_req_val || req_xfer) && (used < 2'd2) && !redirect;
  // Responses tagged with the old epoch belong to the wrong path
  assign resp_drop = imem_resp_val && (imem_resp_msg.opaque[0] != epoch);
  assign fetch_val = (rsp_ptr != rd_ptr);
  assign deq       = fetch_val && fetch_rdy;

  always_comb begin
    imem_req_msg.op     = MEM_READ;
    imem_req_msg.opaque = {{(OPAQ_BITS-1){1'b0}}, req_epoch};
    imem_req_msg.addr   = req_pc;
    imem_req_msg.data   = '0;
    fetch_msg.pc        = q_pc[rd_ptr[0]];
    fetch_msg.inst      = q_inst[rd_ptr[0]];
  end

  //------------------------------
  // Control state
  //------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= '0;
      epoch        <= 1'b0;
      imem_req_val <= 1'b0;
      wr_ptr       <= '0;
      rsp_ptr      <= '0;
      rd_ptr       <= '0;
    end else begin
      if (redirect) begin
        pc    <= redirect_pc;
        epoch <= ~epoch;
      end else if (issue_ok) begin
        pc <= pc + 32'd4;
      end
      if (issue_ok) begin
        imem_req_val <= 1'b1;
      end else if (req_xfer) begin
        imem_req_val <= 1'b0;
      end
      if (req_xfer) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      // In-order memory so each response fills the next pending slot
      if (imem_resp_val) begin
        rsp_ptr <= rsp_ptr + 2'd1;
      end
      // Redirect flushes every slot that already holds an instruction
      if (redirect) begin
        rd_ptr <= rsp_ptr + {1'b0, imem_resp_val};
      end else if (resp_drop || deq) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (issue_ok) begin
      req_pc    <= pc;
      req_epoch <= epoch;
    end
    if (req_xfer) begin
      q_pc[wr_ptr[0]] <= req_pc;
    end
    if (imem_resp_val) begin
      q_inst[rsp_ptr[0]] <= imem_resp_msg.data;
    end
  end

endmodule

// ==== blimp_regfile.sv ====
//------------------------------
// Architectural register file,
// two read ports and x0 tied to zero
//------------------------------
`timescale 1ns/1ps

module blimp_regfile
  import blimp_pkg::*;
(
  input  logic            clk,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  output logic [XLEN-1:0] rdata1,
  output logic [XLEN-1:0] rdata2,
  input  logic            wen,
  input  logic [4:0]      waddr,
  input  logic [XLEN-1:0] wdata
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // Entry 0 is never written
  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Asynchronous reads
  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== blimp_decode.sv ====
//------------------------------
// Decode stage: one instruction buffer,
// format decode and operand read
//------------------------------
`timescale 1ns/1ps

module blimp_decode
  import blimp_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            fetch_val,
  output logic            fetch_rdy,
  input  fetch_msg_t      fetch_msg,
  output logic            issue_val,
  input  logic            issue_rdy,
  output issue_msg_t      issue_msg,
  input  logic            redirect,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  input  logic [XLEN-1:0] rdata1,
  input  logic [XLEN-1:0] rdata2
);

  fetch_msg_t      held;
  logic            held_val;
  inst_t           inst;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_j;

  // Take a new word when empty or when the current one leaves
  assign fetch_rdy = !held_val || issue_rdy;
  assign issue_val = held_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_val <= 1'b0;
    end else if (redirect) begin
      // Wrong-path instruction
      held_val <= 1'b0;
    end else if (fetch_val && fetch_rdy) begin
      held_val <= 1'b1;
    end else if (issue_rdy) begin
      held_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_val && fetch_rdy) begin
      held <= fetch_msg;
    end
  end

  //------------------------------
  // Field decode
  //------------------------------

  assign inst = held.inst;

  // Register indices sit in the same bits in every format
  assign rs1 = inst.r_fmt.rs1;
  assign rs2 = inst.r_fmt.rs2;

  // Sign-extended immediates
  assign imm_i = {{(XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{(XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_j = {{(XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    issue_msg.pc   = held.pc;
    issue_msg.rd   = inst.r_fmt.rd;
    issue_msg.op_a = rdata1;
    issue_msg.op_b = rdata2;
    issue_msg.imm  = imm_i;
    issue_msg.uop  = UOP_ADDI;
    case (inst.r_fmt.opcode)
      OPC_OP: begin
        if (inst.r_fmt.funct7 == OPC_F7_MULDIV) begin
          issue_msg.uop = UOP_MUL;
        end else begin
          issue_msg.uop = UOP_ADD;
        end
      end
      OPC_OP_IMM: issue_msg.uop = UOP_ADDI;
      OPC_LOAD:   issue_msg.uop = UOP_LW;
      OPC_STORE: begin
        // rd bits hold imm_lo here
        issue_msg.uop = UOP_SW;
        issue_msg.rd  = '0;
        issue_msg.imm = imm_s;
      end
      OPC_JAL: begin
        issue_msg.uop = UOP_JAL;
        issue_msg.imm = imm_j;
      end
      OPC_JALR:   issue_msg.uop = UOP_JALR;
      default: begin
        // Unknown opcode runs as a nop
        issue_msg.rd = '0;
      end
    endcase
  end

endmodule

// ==== blimp_execute.sv ====
//------------------------------
// Execute stage: ALU, multiply, jumps,
// data memory access, writeback and trace
//------------------------------
`timescale 1ns/1ps

module blimp_execute
  import blimp_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            issue_val,
  output logic            issue_rdy,
  input  issue_msg_t      issue_msg,
  output logic            dmem_req_val,
  input  logic            dmem_req_rdy,
  output mem_req_t        dmem_req_msg,
  input  logic            dmem_resp_val,
  output logic            dmem_resp_rdy,
  input  mem_resp_t       dmem_resp_msg,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc,
  output logic            rf_wen,
  output logic [4:0]      rf_waddr,
  output logic [XLEN-1:0] rf_wdata,
  output trace_t          trace
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM_REQ,
    ST_MEM_RESP
  } state_e;

  state_e          state;
  issue_msg_t      cur;
  // Single-cycle result waiting for writeback
  logic            alu_done;
  logic            mem_done;
  logic            wb_fire;
  logic            issue_xfer;
  logic            is_mem;
  logic            is_jump;
  logic [XLEN-1:0] base_sum;
  logic [XLEN-1:0] product;
  logic [XLEN-1:0] result;

  // Not idle during writeback, so decode never reads a stale register
  assign issue_rdy  = (state == ST_IDLE) && !alu_done;
  assign issue_xfer = issue_val && issue_rdy;
  assign is_mem     = (issue_msg.uop == UOP_LW) || (issue_msg.uop == UOP_SW);

  //------------------------------
  // FSM
  //------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      alu_done <= 1'b0;
    end else begin
      alu_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (issue_xfer && is_mem) begin
            state <= ST_MEM_REQ;
          end else if (issue_xfer) begin
            alu_done <= 1'b1;
          end
        end
        ST_MEM_REQ: begin
          if (dmem_req_rdy) begin
            state <= ST_MEM_RESP;
          end
        end
        ST_MEM_RESP: begin
          if (dmem_resp_val) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_xfer) begin
      cur <= issue_msg;
    end
  end

  //------------------------------
  // Datapath
  //------------------------------

  // rs1 + imm serves addi, load/store address and jalr
  assign base_sum = cur.op_a + cur.imm;
  // Low word only, same for signed and unsigned
  assign product  = cur.op_a * cur.op_b;

  always_comb begin
    case (cur.uop)
      UOP_ADD:  result = cur.op_a + cur.op_b;
      UOP_ADDI: result = base_sum;
      UOP_MUL:  result = product;
      UOP_LW:   result = dmem_resp_msg.data;
      UOP_JAL:  result = cur.pc + 32'd4;
      UOP_JALR: result = cur.pc + 32'd4;
      default:  result = '0;
    endcase
  end

  // Jumps redirect in their trace cycle
  assign is_jump     = (cur.uop == UOP_JAL) || (cur.uop == UOP_JALR);
  assign redirect    = alu_done && is_jump;
  assign redirect_pc = (cur.uop == UOP_JALR) ? {base_sum[XLEN-1:1], 1'b0} : cur.pc + cur.imm;

  // Data memory, word access only
  assign dmem_req_val  = (state == ST_MEM_REQ);
  assign dmem_resp_rdy = (state == ST_MEM_RESP);

  always_comb begin
    dmem_req_msg.op     = (cur.uop == UOP_SW) ? MEM_WRITE : MEM_READ;
    dmem_req_msg.opaque = '0;
    dmem_req_msg.addr   = base_sum;
    dmem_req_msg.data   = cur.op_b;
  end

  //------------------------------
  // Writeback and trace
  //------------------------------

  assign mem_done = (state == ST_MEM_RESP) && dmem_resp_val;
  assign wb_fire  = alu_done || mem_done;

  assign rf_wen   = wb_fire && (cur.uop != UOP_SW) && (cur.rd != 5'd0);
  assign rf_waddr = cur.rd;
  assign rf_wdata = result;

  always_comb begin
    trace.val   = wb_fire;
    trace.pc    = cur.pc;
    trace.waddr = cur.rd;
    trace.wdata = result;
    trace.wen   = rf_wen;
  end

endmodule

// ==== blimp_core.sv ====
//------------------------------
// Core top: fetch, decode, execute
// and register file
//------------------------------
`timescale 1ns/1ps

module blimp_core
  import blimp_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  output logic      imem_req_val,
  input  logic      imem_req_rdy,
  output mem_req_t  imem_req_msg,
  input  logic      imem_resp_val,
  output logic      imem_resp_rdy,
  input  mem_resp_t imem_resp_msg,
  output logic      dmem_req_val,
  input  logic      dmem_req_rdy,
  output mem_req_t  dmem_req_msg,
  input  logic      dmem_resp_val,
  output logic      dmem_resp_rdy,
  input  mem_resp_t dmem_resp_msg,
  output trace_t    trace
);

  // Fetch to decode
  logic            fetch_val;
  logic            fetch_rdy;
  fetch_msg_t      fetch_msg;
  // Decode to execute
  logic            issue_val;
  logic            issue_rdy;
  issue_msg_t      issue_msg;
  // Jump feedback
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  // Register file ports
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic            rf_wen;
  logic [4:0]      rf_waddr;
  logic [XLEN-1:0] rf_wdata;

  blimp_fetch u_fetch (
    .clk, .rst,
    .imem_req_val, .imem_req_rdy, .imem_req_msg,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_msg,
    .fetch_val, .fetch_rdy, .fetch_msg,
    .redirect, .redirect_pc
  );

  blimp_decode u_decode (
    .clk, .rst,
    .fetch_val, .fetch_rdy, .fetch_msg,
    .issue_val, .issue_rdy, .issue_msg,
    .redirect,
    .rs1, .rs2, .rdata1, .rdata2
  );

  blimp_regfile u_regfile (
    .clk,
    .rs1, .rs2, .rdata1, .rdata2,
    .wen   (rf_wen),
    .waddr (rf_waddr),
    .wdata (rf_wdata)
  );

  blimp_execute u_execute (
    .clk, .rst,
    .issue_val, .issue_rdy, .issue_msg,
    .dmem_req_val, .dmem_req_rdy, .dmem_req_msg,
    .dmem_resp_val, .dmem_resp_rdy, .dmem_resp_msg,
    .redirect, .redirect_pc,
    .rf_wen, .rf_waddr, .rf_wdata,
    .trace
  );

endmodule

// ==== blimp_tb_clock.sv ====
//------------------------------
// Testbench clock, 4 ns period,
// and power-on reset for 4 cycles
//------------------------------
`timescale 1ns/1ps

module blimp_tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset released on the fourth rising edge
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== blimp_tb_mem.sv ====
//------------------------------
// Testbench memory server with one shared word array,
// instruction and data ports and LFSR response delays
//------------------------------
`timescale 1ns/1ps

module blimp_tb_mem
  import blimp_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      rand_delay,
  input  logic      imem_req_val,
  output logic      imem_req_rdy,
  input  mem_req_t  imem_req_msg,
  output logic      imem_resp_val,
  input  logic      imem_resp_rdy,
  output mem_resp_t imem_resp_msg,
  input  logic      dmem_req_val,
  output logic      dmem_req_rdy,
  input  mem_req_t  dmem_req_msg,
  output logic      dmem_resp_val,
  input  logic      dmem_resp_rdy,
  output mem_resp_t dmem_resp_msg
);

  localparam int MEM_WORDS = 1024;
  // Loads from here are accepted and never answered so the core parks
  localparam logic [XLEN-1:0] HALT_ADDR = 32'hffff_fffc;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [31:0]     lfsr;
  longint          cycle;

  // Per-port response FIFO with index 0 for instruction and 1 for data
  mem_resp_t       fifo [2][4];
  longint          due [2][4];
  int              head [2];
  int              count [2];
  logic            req_val [2];
  mem_req_t        req_msg [2];
  logic            resp_rdy [2];
  logic            req_rdy [2];
  logic            resp_val [2];
  mem_resp_t       resp_msg [2];

  assign req_val[0]    = imem_req_val;
  assign req_val[1]    = dmem_req_val;
  assign req_msg[0]    = imem_req_msg;
  assign req_msg[1]    = dmem_req_msg;
  assign resp_rdy[0]   = imem_resp_rdy;
  assign resp_rdy[1]   = dmem_resp_rdy;
  assign imem_req_rdy  = req_rdy[0];
  assign dmem_req_rdy  = req_rdy[1];
  assign imem_resp_val = resp_val[0];
  assign dmem_resp_val = resp_val[1];
  assign imem_resp_msg = resp_msg[0];
  assign dmem_resp_msg = resp_msg[1];

  // Galois LFSR step, taken once per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  initial begin
    lfsr  = 32'h2dd3_b4ad;
    cycle = 0;
    // Both ports idle until the first clock edge
    for (int p = 0; p < 2; p++) begin
      req_rdy[p]  <= 1'b0;
      resp_val[p] <= 1'b0;
      resp_msg[p] <= '0;
    end
  end

  //------------------------------
  // Backdoor access
  //------------------------------

  // Every word tagged with its own byte address
  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hbad0_0000 ^ (i << 2);
    end
  endtask

  task automatic load_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    mem[addr[11:2]] = data;
  endtask

  function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] addr);
    read_word = mem[addr[11:2]];
  endfunction

  //------------------------------
  // Port service
  //------------------------------

  always @(posedge clk) begin : serve
    int         p;
    int         slot;
    logic [1:0] d;
    cycle = cycle + 1;
    for (p = 0; p < 2; p++) begin
      if (rst) begin
        head[p]     = 0;
        count[p]    = 0;
        resp_val[p] <= 1'b0;
        req_rdy[p]  <= 1'b0;
      end else begin
        // Head leaves on a response transfer
        if (resp_val[p] && resp_rdy[p]) begin
          head[p]  = (head[p] + 1) % 4;
          count[p] = count[p] - 1;
        end
        if (req_val[p] && req_rdy[p] && (req_msg[p].addr != HALT_ADDR)) begin
          slot = (head[p] + count[p]) % 4;
          fifo[p][slot].op     = req_msg[p].op;
          fifo[p][slot].opaque = req_msg[p].opaque;
          fifo[p][slot].data   = mem[req_msg[p].addr[11:2]];
          if (req_msg[p].op == MEM_WRITE) begin
            mem[req_msg[p].addr[11:2]] = req_msg[p].data;
          end
          // 0 to 3 extra cycles
          d = 2'd0;
          if (rand_delay) begin
            repeat (2) begin
              d    = {d[0], lfsr[0]};
              lfsr = lfsr_next(lfsr);
            end
          end
          due[p][slot] = cycle + d;
          count[p]     = count[p] + 1;
        end
        resp_val[p] <= (count[p] != 0) && (due[p][head[p]] <= cycle);
        resp_msg[p] <= fifo[p][head[p]];
        // Room left for one more push
        req_rdy[p]  <= (count[p] < 3);
      end
    end
  end

endmodule

// ==== blimp_tb.sv ====
//------------------------------
// Testbench top: program and trace table,
// trace and memory compare, timeout, report
//------------------------------
`timescale 1ns/1ps

module blimp_tb
  import blimp_pkg::*;
();

  typedef enum logic [1:0] {
    ROW_PROG,
    ROW_DATA,
    ROW_TRACE,
    ROW_FINAL
  } row_kind_e;

  typedef struct packed {
    row_kind_e       kind;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    trace_t          exp;
  } row_t;

  logic      clk;
  logic      clk_rst;
  logic      rerun_rst;
  logic      rst;
  logic      rand_delay;
  logic      imem_req_val;
  logic      imem_req_rdy;
  mem_req_t  imem_req_msg;
  logic      imem_resp_val;
  logic      imem_resp_rdy;
  mem_resp_t imem_resp_msg;
  logic      dmem_req_val;
  logic      dmem_req_rdy;
  mem_req_t  dmem_req_msg;
  logic      dmem_resp_val;
  logic      dmem_resp_rdy;
  mem_resp_t dmem_resp_msg;
  trace_t    trace;

  row_t      rows [$];
  trace_t    exp_q [$];
  int        errors;
  int        tests;
  logic      timed_out;

  assign rst = clk_rst || rerun_rst;

  blimp_tb_clock clock_gen (.clk, .rst(clk_rst));

  blimp_tb_mem mem_server (
    .clk, .rst, .rand_delay,
    .imem_req_val, .imem_req_rdy, .imem_req_msg,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_msg,
    .dmem_req_val, .dmem_req_rdy, .dmem_req_msg,
    .dmem_resp_val, .dmem_resp_rdy, .dmem_resp_msg
  );

  blimp_core UUT (
    .clk, .rst,
    .imem_req_val, .imem_req_rdy, .imem_req_msg,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_msg,
    .dmem_req_val, .dmem_req_rdy, .dmem_req_msg,
    .dmem_resp_val, .dmem_resp_rdy, .dmem_resp_msg,
    .trace
  );

  //------------------------------
  // Table
  //------------------------------

  task automatic add_word(input row_kind_e kind, input logic [31:0] addr, input logic [31:0] data);
    rows.push_back('{kind, addr, data, '0});
  endtask

  task automatic add_trace(input logic [31:0] pc, input logic [4:0] waddr,
                           input logic [31:0] wdata, input logic wen);
    rows.push_back('{ROW_TRACE, pc, wdata, '{1'b1, pc, waddr, wdata, wen}});
  endtask

  task automatic build_table();
    // Dependency chain, addi to x0 traces with wen low
    add_word(ROW_PROG, 32'h00, 32'h0050_0093);   // addi x1, x0, 5
    add_word(ROW_PROG, 32'h04, 32'hffd0_8113);   // addi x2, x1, -3
    add_word(ROW_PROG, 32'h08, 32'h0020_81b3);   // add  x3, x1, x2
    add_word(ROW_PROG, 32'h0c, 32'h0091_8013);   // addi x0, x3, 9
    // Multiply, negative and large operands
    add_word(ROW_PROG, 32'h10, 32'hff90_0213);   // addi x4, x0, -7
    add_word(ROW_PROG, 32'h14, 32'h7ff0_0293);   // addi x5, x0, 2047
    add_word(ROW_PROG, 32'h18, 32'h0252_0333);   // mul  x6, x4, x5
    add_word(ROW_PROG, 32'h1c, 32'h0252_83b3);   // mul  x7, x5, x5
    add_word(ROW_PROG, 32'h20, 32'h0242_0433);   // mul  x8, x4, x4
    // Store, load back, load preloaded word
    add_word(ROW_PROG, 32'h24, 32'h2000_0493);   // addi x9, x0, 0x200
    add_word(ROW_PROG, 32'h28, 32'h0064_a223);   // sw   x6, 4(x9)
    add_word(ROW_PROG, 32'h2c, 32'h0044_a503);   // lw   x10, 4(x9)
    add_word(ROW_PROG, 32'h30, 32'h0004_a583);   // lw   x11, 0(x9)
    // Jumps, wrong-path words must never trace
    add_word(ROW_PROG, 32'h34, 32'h00c0_00ef);   // jal  x1, +12
    add_word(ROW_PROG, 32'h38, 32'h0010_0613);   // addi x12, x0, 1
    add_word(ROW_PROG, 32'h3c, 32'h0020_0613);   // addi x12, x0, 2
    add_word(ROW_PROG, 32'h40, 32'h0610_0693);   // addi x13, x0, 0x61
    add_word(ROW_PROG, 32'h44, 32'h0106_8767);   // jalr x14, 16(x13)
    add_word(ROW_PROG, 32'h48, 32'h0030_0613);   // addi x12, x0, 3
    add_word(ROW_PROG, 32'h70, 32'h00b7_07b3);   // add  x15, x14, x11
    add_word(ROW_PROG, 32'h74, 32'h00f4_a423);   // sw   x15, 8(x9)
    add_word(ROW_PROG, 32'h78, 32'hffc0_2003);   // lw x0, -4(x0), never answered
    add_word(ROW_DATA, 32'h200, 32'h1234_5678);
    add_trace(32'h00, 5'd1, 32'h0000_0005, 1'b1);
    add_trace(32'h04, 5'd2, 32'h0000_0002, 1'b1);
    add_trace(32'h08, 5'd3, 32'h0000_0007, 1'b1);
    add_trace(32'h0c, 5'd0, 32'h0000_0010, 1'b0);
    add_trace(32'h10, 5'd4, 32'hffff_fff9, 1'b1);
    add_trace(32'h14, 5'd5, 32'h0000_07ff, 1'b1);
    add_trace(32'h18, 5'd6, 32'hffff_c807, 1'b1);
    add_trace(32'h1c, 5'd7, 32'h003f_f001, 1'b1);
    add_trace(32'h20, 5'd8, 32'h0000_0031, 1'b1);
    add_trace(32'h24, 5'd9, 32'h0000_0200, 1'b1);
    add_trace(32'h28, 5'd0, 32'h0000_0000, 1'b0);
    add_trace(32'h2c, 5'd10, 32'hffff_c807, 1'b1);
    add_trace(32'h30, 5'd11, 32'h1234_5678, 1'b1);
    add_trace(32'h34, 5'd1, 32'h0000_0038, 1'b1);
    add_trace(32'h40, 5'd13, 32'h0000_0061, 1'b1);
    add_trace(32'h44, 5'd14, 32'h0000_0048, 1'b1);
    add_trace(32'h70, 5'd15, 32'h1234_56c0, 1'b1);
    add_trace(32'h74, 5'd0, 32'h0000_0000, 1'b0);
    add_word(ROW_FINAL, 32'h200, 32'h1234_5678);
    add_word(ROW_FINAL, 32'h204, 32'hffff_c807);
    add_word(ROW_FINAL, 32'h208, 32'h1234_56c0);
  endtask

  //------------------------------
  // Compare tasks
  //------------------------------

  task automatic check_trace(input trace_t got, input trace_t exp, input int idx);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: trace %0d pc %h x%0d=%h wen %b, expected pc %h x%0d=%h wen %b",
               $time, idx, got.pc, got.waddr, got.wdata, got.wen,
               exp.pc, exp.waddr, exp.wdata, exp.wen);
    end
  endtask

  task automatic check_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    tests++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: memory %h holds %h, expected %h", $time, addr, got, exp);
    end else begin
      $display("memory %h: ok", addr);
    end
  endtask

  //------------------------------
  // One program run
  //------------------------------

  task automatic run_pass(input logic mode);
    int got;
    int extra;
    int cycles;
    int limit;
    int err0;
    err0  = errors;
    got   = 0;
    extra = 0;
    cycles = 0;
    limit = exp_q.size() * 20 + 100;
    @(posedge clk);
    rerun_rst  <= 1'b1;
    rand_delay <= mode;
    mem_server.fill_memory();
    foreach (rows[i]) begin
      if (rows[i].kind == ROW_PROG || rows[i].kind == ROW_DATA) begin
        mem_server.load_word(rows[i].addr, rows[i].data);
      end
    end
    repeat (4) @(posedge clk);
    rerun_rst <= 1'b0;
    // Traces checked in order, at the falling edge
    while (got < exp_q.size() && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (trace.val) begin
        check_trace(trace, exp_q[got], got);
        got++;
      end
    end
    if (got < exp_q.size()) begin
      timed_out = 1'b1;
      $display("Timeout in run %0d: only %0d of %0d traces arrived within %0d cycles",
               mode, got, exp_q.size(), limit);
    end else begin
      repeat (20) begin
        @(negedge clk);
        if (trace.val) extra++;
      end
      if (extra != 0) begin
        errors++;
        $display("Run %0d produced %0d traces after the last expected one", mode, extra);
      end
    end
    tests++;
    $display("run %0d (%s delays): %0d traces, %0d errors", mode,
             mode ? "random" : "fixed", got, errors - err0);
  endtask

  initial begin
    rerun_rst  = 1'b0;
    rand_delay = 1'b0;
    errors     = 0;
    tests      = 0;
    timed_out  = 1'b0;
    build_table();
    foreach (rows[i]) begin
      if (rows[i].kind == ROW_TRACE) exp_q.push_back(rows[i].exp);
    end
    run_pass(1'b0);
    if (!timed_out) run_pass(1'b1);
    if (!timed_out) begin
      foreach (rows[i]) begin
        if (rows[i].kind == ROW_FINAL) begin
          check_word(rows[i].addr, mem_server.read_word(rows[i].addr), rows[i].data);
        end
      end
    end
    $display("%0d tests, %0d errors, timeout %b", tests, errors, timed_out);
    if (timed_out || errors != 0) begin
      $display("Regression failed");
    end else begin
      $display("Regression passed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
blimp_pkg.sv
blimp_fetch.sv
blimp_regfile.sv
blimp_decode.sv
blimp_execute.sv
blimp_core.sv
blimp_tb_clock.sv
blimp_tb_mem.sv
blimp_tb.sv

// ==== Bender.yml ====
package:
  name: blimp

sources:
  - blimp_pkg.sv
  - blimp_fetch.sv
  - blimp_regfile.sv
  - blimp_decode.sv
  - blimp_execute.sv
  - blimp_core.sv
  - target: test
    files:
      - blimp_tb_clock.sv
      - blimp_tb_mem.sv
      - blimp_tb.sv
